/* tb/core_cases.txt */
// ir       pc       wen rd wdata    taken next_pc  ecode
// One instruction per line, wdata and rd only matter when wen is 1; ir ffffffff ends the list
142468a4 1c000000 1 04 12345000 0 1c000004 00
0399e084 1c000004 1 04 12345678 0 1c000008 00
02bffc05 1c000008 1 05 ffffffff 0 1c00000c 00
037ffca6 1c00000c 1 06 00000fff 0 1c000010 00
020000a7 1c000010 1 07 00000001 0 1c000014 00
027ffcc8 1c000014 1 08 00000001 0 1c000018 00
03c3fc89 1c000018 1 09 12345687 0 1c00001c 00
1c00002a 1c00001c 1 0a 1c00101c 0 1c000020 00
0010148b 1c000020 1 0b 12345677 0 1c000024 00
0011116c 1c000024 1 0c ffffffff 0 1c000028 00
00121d8d 1c000028 1 0d 00000001 0 1c00002c 00
00129d8e 1c00002c 1 0e 00000000 0 1c000030 00
0014008f 1c000030 1 0f edcba987 0 1c000034 00
0014a490 1c000034 1 10 12345600 0 1c000038 00
00152491 1c000038 1 11 123456ff 0 1c00003c 00
0015a492 1c00003c 1 12 000000ff 0 1c000040 00
00171c93 1c000040 1 13 2468acf0 0 1c000044 00
0017c8b4 1c000044 1 14 00000001 0 1c000048 00
00181df5 1c000048 1 15 f6e5d4c3 0 1c00004c 00
004090d6 1c00004c 1 16 0000fff0 0 1c000050 00
0044f1f7 1c000050 1 17 0000000e 0 1c000054 00
0048f1f8 1c000054 1 18 fffffffe 0 1c000058 00
02848c80 1c000058 1 00 1234579b 0 1c00005c 00
00150019 1c00005c 1 19 00000000 0 1c000060 00
58001089 1c000060 0 00 00000000 0 1c000064 00
580010e8 1c000064 0 00 00000000 1 1c000074 00
5c0010e8 1c000068 0 00 00000000 0 1c00006c 00
5ffffc89 1c00006c 0 00 00000000 1 1c000068 00
60002187 1c000070 0 00 00000000 1 1c000090 00
600020ec 1c000074 0 00 00000000 0 1c000078 00
640020ec 1c000078 0 00 00000000 1 1c000098 00
64002187 1c00007c 0 00 00000000 0 1c000080 00
680020ec 1c000080 0 00 00000000 1 1c0000a0 00
68002187 1c000084 0 00 00000000 0 1c000088 00
6c002187 1c000088 0 00 00000000 1 1c0000a8 00
6c0020ec 1c00008c 0 00 00000000 0 1c000090 00
50010000 1c000090 0 00 00000000 1 1c000190 00
57fffbff 1c000094 1 01 1c000098 1 1c00008c 00
4c001022 1c000098 1 02 1c00009c 1 1c0000a8 00
002b0000 1c00009c 0 00 00000000 0 1c0000a0 0b
002a0000 1c0000a0 0 00 00000000 0 1c0000a4 0c
001c1083 1c0000a4 0 00 00000000 0 1c0000a8 0d
02800483 1c0000aa 0 00 00000000 0 1c0000ae 08
0015007a 1c0000ac 1 1a 00000000 0 1c0000b0 00
ffffffff ffffffff 0 00 00000000 0 00000000 00

/* verilog.f */
verilog/la32_pkg.sv
verilog/la32_decoder.sv
verilog/la32_execute.sv
verilog/la32_regfile_wb.sv
verilog/la32_core.sv
tb/tb_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_core
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= SIMULATION PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* tb/tb_core.sv */
`default_nettype none

module tb_core;

    localparam int PERIOD = 100;
    localparam int MAX_CASES = 64;
    localparam int FIELDS = 8; // ir, pc, wen, rd, wdata, taken, next_pc, ecode
    localparam int TIMEOUT_CYCLES = 20;
    localparam longint RESULT_DELAY = 2 * PERIOD + PERIOD / 2; // Sampled on the falling edge
    localparam logic [31:0] END_MARK = 32'hffffffff;

    logic                 clk;
    logic                 reset;
    logic                 in_valid;
    la32_pkg::word_t      in_ir;
    la32_pkg::word_t      in_pc;
    logic                 out_valid;
    la32_pkg::word_t      out_pc;
    la32_pkg::reg_idx_t   out_rd;
    logic                 out_wen;
    la32_pkg::word_t      out_wdata;
    logic                 out_taken;
    la32_pkg::word_t      out_next_pc;
    la32_pkg::ecode_t     out_excp;

    logic [31:0] cases [0:MAX_CASES*FIELDS-1];
    int          num_cases;
    int          idx_q[$];    // Case index of each instruction in flight
    longint      time_q[$];   // Strobe time of each instruction in flight

    la32_core dut0 (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .in_ir(in_ir),
        .in_pc(in_pc),
        .out_valid(out_valid),
        .out_pc(out_pc),
        .out_rd(out_rd),
        .out_wen(out_wen),
        .out_wdata(out_wdata),
        .out_taken(out_taken),
        .out_next_pc(out_next_pc),
        .out_excp(out_excp)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD/2) clk = ~clk;
    end

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped");
    endtask

    task automatic report_mismatch(input string msg);
        stop_with_failure($sformatf("MISMATCH at time %0t: %s", $time, msg));
    endtask

    task automatic check_word(input string what, input la32_pkg::word_t got,
                              input la32_pkg::word_t exp);
        if (got !== exp)
            report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_idx(input string what, input la32_pkg::reg_idx_t got,
                             input la32_pkg::reg_idx_t exp);
        if (got !== exp)
            report_mismatch($sformatf("%s is r%0d, expected r%0d", what, got, exp));
    endtask

    task automatic check_ecode(input string what, input la32_pkg::ecode_t got,
                               input la32_pkg::ecode_t exp);
        if (got !== exp)
            report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp)
            report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic load_cases;
        $readmemh("tb/core_cases.txt", cases);
        num_cases = 0;
        while (num_cases < MAX_CASES && cases[num_cases * FIELDS] !== END_MARK)
            num_cases++;
        if (num_cases == MAX_CASES || num_cases == 0)
            stop_with_failure("ERROR: case file is missing, empty or has no end marker");
    endtask

    task automatic drive_cases;
        int gap;
        for (int i = 0; i < num_cases; i++)
        begin
            gap = $urandom % 3;
            repeat (gap)
            begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
            @(posedge clk);
            in_valid <= 1'b1;
            in_ir <= cases[i * FIELDS];
            in_pc <= cases[i * FIELDS + 1];
            idx_q.push_back(i);
            time_q.push_back(longint'($time));
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_for_result;
        int waited;
        waited = 0;
        @(negedge clk);
        while (!out_valid)
        begin
            waited++;
            if (waited > TIMEOUT_CYCLES)
                stop_with_failure("ERROR: no result arrived within the timeout");
            @(negedge clk);
        end
    endtask

    task automatic check_results;
        int     idx;
        int     base;
        longint t;
        string  tag;
        for (int n = 0; n < num_cases; n++)
        begin
            wait_for_result();
            if (idx_q.size() == 0)
                stop_with_failure("ERROR: a result arrived with no instruction in flight");
            idx = idx_q.pop_front();
            t = time_q.pop_front();
            base = idx * FIELDS;
            tag = $sformatf("case %0d", idx);
            if (longint'($time) != t + RESULT_DELAY)
                report_mismatch($sformatf("%s result came late or early, strobe at %0d",
                                          tag, t));
            check_word({tag, " pc"}, out_pc, cases[base + 1]);
            check_bit({tag, " wen"}, out_wen, cases[base + 2][0]);
            if (cases[base + 2][0])
            begin
                check_idx({tag, " rd"}, out_rd, cases[base + 3][4:0]);
                check_word({tag, " wdata"}, out_wdata, cases[base + 4]);
            end
            check_bit({tag, " taken"}, out_taken, cases[base + 5][0]);
            check_word({tag, " next_pc"}, out_next_pc, cases[base + 6]);
            check_ecode({tag, " ecode"}, out_excp, la32_pkg::ecode_t'(cases[base + 7][5:0]));
        end
        repeat (4)
        begin
            @(negedge clk);
            check_bit("out_valid after the last result", out_valid, 1'b0);
        end
    endtask

    initial
    begin
        reset = 1'b1;
        in_valid = 1'b0;
        in_ir = '0;
        in_pc = '0;
        void'($urandom(28));
        load_cases();
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_bit("out_valid after reset", out_valid, 1'b0);
        fork
            drive_cases();
            check_results();
        join
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/la32_core.sv */
`default_nettype none

module la32_core (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  in_valid,
    input  wire la32_pkg::word_t in_ir,
    input  wire la32_pkg::word_t in_pc,
    output logic                 out_valid,
    output la32_pkg::word_t      out_pc,
    output la32_pkg::reg_idx_t   out_rd,
    output logic                 out_wen,
    output la32_pkg::word_t      out_wdata,
    output logic                 out_taken,
    output la32_pkg::word_t      out_next_pc,
    output la32_pkg::ecode_t     out_excp
);

    // Decode to execute
    logic               d_valid;
    la32_pkg::word_t    d_pc;
    la32_pkg::reg_idx_t d_rj;
    la32_pkg::reg_idx_t d_rk;
    la32_pkg::reg_idx_t d_rd;
    logic               d_wen;
    la32_pkg::word_t    d_imm;
    logic               d_use_imm;
    logic               d_use_pc;
    la32_pkg::alu_op_t  d_alu_op;
    la32_pkg::br_cond_t d_br_cond;
    logic               d_jirl;
    logic               d_link;
    la32_pkg::ecode_t   d_excp;

    // Register file read ports
    la32_pkg::reg_idx_t rj_idx;
    la32_pkg::reg_idx_t rk_idx;
    la32_pkg::word_t    rj_val;
    la32_pkg::word_t    rk_val;

    // Execute to result stage
    logic               e_valid;
    la32_pkg::word_t    e_pc;
    la32_pkg::reg_idx_t e_rd;
    logic               e_wen;
    la32_pkg::word_t    e_wdata;
    logic               e_taken;
    la32_pkg::word_t    e_next_pc;
    la32_pkg::ecode_t   e_excp;

    la32_decoder u_decoder (.*);

    la32_execute u_execute (.*);

    la32_regfile_wb u_regfile_wb (.*);

endmodule

`default_nettype wire

/* verilog/la32_regfile_wb.sv */
`default_nettype none

module la32_regfile_wb (
    input  wire                     clk,
    input  wire                     reset,
    input  wire la32_pkg::reg_idx_t rj_idx,
    input  wire la32_pkg::reg_idx_t rk_idx,
    input  wire                     e_valid,
    input  wire la32_pkg::word_t    e_pc,
    input  wire la32_pkg::reg_idx_t e_rd,
    input  wire                     e_wen,
    input  wire la32_pkg::word_t    e_wdata,
    input  wire                     e_taken,
    input  wire la32_pkg::word_t    e_next_pc,
    input  wire la32_pkg::ecode_t   e_excp,
    output la32_pkg::word_t         rj_val,
    output la32_pkg::word_t         rk_val,
    output logic                    out_valid,
    output la32_pkg::word_t         out_pc,
    output la32_pkg::reg_idx_t      out_rd,
    output logic                    out_wen,
    output la32_pkg::word_t         out_wdata,
    output logic                    out_taken,
    output la32_pkg::word_t         out_next_pc,
    output la32_pkg::ecode_t        out_excp
);

    la32_pkg::word_t regs [1:la32_pkg::NREGS-1]; // r0 is hardwired
    logic            wr_en;

    assign wr_en = e_valid && e_wen && (e_rd != '0);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 1; i < la32_pkg::NREGS; i++)
                regs[i] <= '0;
        end
        else if (wr_en)
            regs[e_rd] <= e_wdata;
    end

    function automatic la32_pkg::word_t read_port(input la32_pkg::reg_idx_t idx);
        if (idx == '0)
            return '0;
        if (wr_en && idx == e_rd)
            return e_wdata; // Write-first bypass
        return regs[idx];
    endfunction

    always_comb
    begin
        rj_val = read_port(rj_idx);
        rk_val = read_port(rk_idx);
    end

    assign out_valid = e_valid;
    assign out_pc = e_pc;
    assign out_rd = e_rd;
    assign out_wen = e_wen;
    assign out_wdata = e_wdata;
    assign out_taken = e_taken;
    assign out_next_pc = e_next_pc;
    assign out_excp = e_excp;

    a_no_write_on_excp: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> out_excp == la32_pkg::ECODE_NONE)
        else $error("Register write from a faulting instruction");

endmodule

`default_nettype wire

/* verilog/la32_execute.sv */
`default_nettype none

module la32_execute (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     d_valid,
    input  wire la32_pkg::word_t    d_pc,
    input  wire la32_pkg::reg_idx_t d_rj,
    input  wire la32_pkg::reg_idx_t d_rk,
    input  wire la32_pkg::reg_idx_t d_rd,
    input  wire                     d_wen,
    input  wire la32_pkg::word_t    d_imm,
    input  wire                     d_use_imm,
    input  wire                     d_use_pc,
    input  wire la32_pkg::alu_op_t  d_alu_op,
    input  wire la32_pkg::br_cond_t d_br_cond,
    input  wire                     d_jirl,
    input  wire                     d_link,
    input  wire la32_pkg::ecode_t   d_excp,
    input  wire la32_pkg::word_t    rj_val,
    input  wire la32_pkg::word_t    rk_val,
    output la32_pkg::reg_idx_t      rj_idx,
    output la32_pkg::reg_idx_t      rk_idx,
    output logic                    e_valid,
    output la32_pkg::word_t         e_pc,
    output la32_pkg::reg_idx_t      e_rd,
    output logic                    e_wen,
    output la32_pkg::word_t         e_wdata,
    output logic                    e_taken,
    output la32_pkg::word_t         e_next_pc,
    output la32_pkg::ecode_t        e_excp
);

    la32_pkg::word_t op_a;
    la32_pkg::word_t op_b;
    la32_pkg::word_t alu_res;
    la32_pkg::word_t pc_plus4;
    la32_pkg::word_t target;
    logic [4:0]      shamt;
    logic            taken;

    assign rj_idx = d_rj;
    assign rk_idx = d_rk;

    assign op_a = d_use_pc ? d_pc : rj_val;
    assign op_b = d_use_imm ? d_imm : rk_val;
    assign shamt = op_b[4:0];

    always_comb
    begin
        case (d_alu_op)
            la32_pkg::ALU_AND: alu_res = op_a & op_b;
            la32_pkg::ALU_OR: alu_res = op_a | op_b;
            la32_pkg::ALU_NOR: alu_res = ~(op_a | op_b);
            la32_pkg::ALU_XOR: alu_res = op_a ^ op_b;
            la32_pkg::ALU_ADD: alu_res = op_a + op_b;
            la32_pkg::ALU_SUB: alu_res = op_a - op_b;
            la32_pkg::ALU_SLL: alu_res = op_a << shamt;
            la32_pkg::ALU_SRL: alu_res = op_a >> shamt;
            la32_pkg::ALU_SRA: alu_res = $signed(op_a) >>> shamt;
            la32_pkg::ALU_SLT: alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            la32_pkg::ALU_SLTU: alu_res = {31'b0, op_a < op_b};
            default: alu_res = op_b;
        endcase
    end

    always_comb
    begin
        case (d_br_cond)
            la32_pkg::BR_ALWAYS: taken = 1'b1;
            la32_pkg::BR_EQ: taken = rj_val == rk_val;
            la32_pkg::BR_NE: taken = rj_val != rk_val;
            la32_pkg::BR_LT: taken = $signed(rj_val) < $signed(rk_val);
            la32_pkg::BR_GE: taken = $signed(rj_val) >= $signed(rk_val);
            la32_pkg::BR_LTU: taken = rj_val < rk_val;
            la32_pkg::BR_GEU: taken = rj_val >= rk_val;
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus4 = d_pc + 32'd4;
    assign target = d_jirl ? rj_val + d_imm : d_pc + d_imm;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            e_valid <= 1'b0;
            e_wen <= 1'b0;
            e_taken <= 1'b0;
            e_excp <= la32_pkg::ECODE_NONE;
        end
        else
        begin
            e_valid <= d_valid;
            e_wen <= d_wen;
            e_taken <= taken;
            e_excp <= d_excp;
        end
    end

    always_ff @(posedge clk)
    begin
        e_pc <= d_pc;
        e_rd <= d_rd;
        e_wdata <= d_link ? pc_plus4 : alu_res; // BL and JIRL link
        e_next_pc <= taken ? target : pc_plus4;
    end

    a_taken_no_excp: assert property (@(posedge clk) disable iff (reset)
        e_taken |-> e_excp == la32_pkg::ECODE_NONE)
        else $error("Faulting instruction resolved as a taken branch");

endmodule

`default_nettype wire

/* verilog/la32_decoder.sv */
`default_nettype none

module la32_decoder (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  in_valid,
    input  wire la32_pkg::word_t in_ir,
    input  wire la32_pkg::word_t in_pc,
    output logic                 d_valid,
    output la32_pkg::word_t      d_pc,
    output la32_pkg::reg_idx_t   d_rj,
    output la32_pkg::reg_idx_t   d_rk,
    output la32_pkg::reg_idx_t   d_rd,
    output logic                 d_wen,
    output la32_pkg::word_t      d_imm,
    output logic                 d_use_imm,
    output logic                 d_use_pc,
    output la32_pkg::alu_op_t    d_alu_op,
    output la32_pkg::br_cond_t   d_br_cond,
    output logic                 d_jirl,
    output logic                 d_link,
    output la32_pkg::ecode_t     d_excp
);

    la32_pkg::opcode_t  opcode;
    la32_pkg::reg_idx_t rj;
    la32_pkg::reg_idx_t rk;
    la32_pkg::reg_idx_t rd;
    la32_pkg::word_t    imm;
    la32_pkg::word_t    sext12;
    la32_pkg::word_t    zext12;
    la32_pkg::word_t    off16;
    la32_pkg::word_t    off26;
    la32_pkg::alu_op_t  alu_op;
    la32_pkg::br_cond_t br_cond;
    la32_pkg::ecode_t   excp;
    logic               wen;
    logic               use_imm;
    logic               use_pc;
    logic               jirl;
    logic               link;
    logic               hit; // Encoding recognised

    assign opcode = la32_pkg::opcode_t'(in_ir[31:26]);
    assign sext12 = {{20{in_ir[21]}}, in_ir[21:10]};
    assign zext12 = {20'b0, in_ir[21:10]};
    assign off16  = {{14{in_ir[25]}}, in_ir[25:10], 2'b00};
    assign off26  = {{4{in_ir[9]}}, in_ir[9:0], in_ir[25:10], 2'b00};

    always_comb
    begin
        rj = in_ir[9:5];
        rk = in_ir[14:10];
        rd = in_ir[4:0];
        imm = '0;
        wen = 1'b0;
        use_imm = 1'b0;
        use_pc = 1'b0;
        alu_op = la32_pkg::ALU_ADD;
        br_cond = la32_pkg::BR_NONE;
        jirl = 1'b0;
        link = 1'b0;
        hit = 1'b0;
        excp = la32_pkg::ECODE_INE;
        case (opcode)
            la32_pkg::OP_GRP0:
            begin
                hit = 1'b1;
                wen = 1'b1;
                use_imm = in_ir[25:22] != 4'b0000;
                // Logic ops zero-extend, arithmetic sign-extends, shifts take ui5
                imm = in_ir[25] ? (in_ir[24] ? zext12 : sext12) : {27'b0, in_ir[14:10]};
                case (in_ir[25:22])
                    4'b0000:
                        case (in_ir[21:15])
                            7'b0100000: alu_op = la32_pkg::ALU_ADD;
                            7'b0100010: alu_op = la32_pkg::ALU_SUB;
                            7'b0100100: alu_op = la32_pkg::ALU_SLT;
                            7'b0100101: alu_op = la32_pkg::ALU_SLTU;
                            7'b0101000: alu_op = la32_pkg::ALU_NOR;
                            7'b0101001: alu_op = la32_pkg::ALU_AND;
                            7'b0101010: alu_op = la32_pkg::ALU_OR;
                            7'b0101011: alu_op = la32_pkg::ALU_XOR;
                            7'b0101110: alu_op = la32_pkg::ALU_SLL;
                            7'b0101111: alu_op = la32_pkg::ALU_SRL;
                            7'b0110000: alu_op = la32_pkg::ALU_SRA;
                            7'b1010100:
                            begin
                                hit = 1'b0;
                                excp = la32_pkg::ECODE_BRK;
                            end
                            7'b1010110:
                            begin
                                hit = 1'b0;
                                excp = la32_pkg::ECODE_SYS;
                            end
                            default: hit = 1'b0; // MUL, DIV and the rest
                        endcase
                    4'b0001:
                        if (in_ir[21:20] == 2'b00 && in_ir[17:15] == 3'b001)
                            case (in_ir[19:18])
                                2'b00: alu_op = la32_pkg::ALU_SLL;
                                2'b01: alu_op = la32_pkg::ALU_SRL;
                                2'b10: alu_op = la32_pkg::ALU_SRA;
                                default: hit = 1'b0;
                            endcase
                        else
                            hit = 1'b0;
                    4'b1000: alu_op = la32_pkg::ALU_SLT;
                    4'b1001: alu_op = la32_pkg::ALU_SLTU;
                    4'b1010: alu_op = la32_pkg::ALU_ADD;
                    4'b1101: alu_op = la32_pkg::ALU_AND;
                    4'b1110: alu_op = la32_pkg::ALU_OR;
                    4'b1111: alu_op = la32_pkg::ALU_XOR;
                    default: hit = 1'b0;
                endcase
            end
            la32_pkg::OP_LU12I, la32_pkg::OP_PCADDU12I:
            begin
                hit = !in_ir[25];
                wen = 1'b1;
                use_imm = 1'b1;
                imm = {in_ir[24:5], 12'b0};
                if (opcode == la32_pkg::OP_LU12I)
                    alu_op = la32_pkg::ALU_PASS_B;
                else
                    use_pc = 1'b1;
            end
            la32_pkg::OP_JIRL:
            begin
                hit = 1'b1;
                wen = 1'b1;
                link = 1'b1;
                jirl = 1'b1;
                br_cond = la32_pkg::BR_ALWAYS;
                imm = off16;
            end
            la32_pkg::OP_B, la32_pkg::OP_BL:
            begin
                hit = 1'b1;
                wen = opcode == la32_pkg::OP_BL;
                link = opcode == la32_pkg::OP_BL;
                rd = 5'd1; // Return address register
                br_cond = la32_pkg::BR_ALWAYS;
                imm = off26;
            end
            la32_pkg::OP_BEQ, la32_pkg::OP_BNE, la32_pkg::OP_BLT,
            la32_pkg::OP_BGE, la32_pkg::OP_BLTU, la32_pkg::OP_BGEU:
            begin
                hit = 1'b1;
                rk = in_ir[4:0]; // Compare against rd
                imm = off16;
                br_cond = la32_pkg::br_cond_t'(3'(in_ir[31:26] - 6'h14));
            end
            default: ;
        endcase
        if (hit)
            excp = la32_pkg::ECODE_NONE;
        if (in_pc[1:0] != 2'b00)
            excp = la32_pkg::ECODE_ADEF; // Beats any decode
        if (excp != la32_pkg::ECODE_NONE)
        begin
            wen = 1'b0;
            br_cond = la32_pkg::BR_NONE;
            jirl = 1'b0;
            link = 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            d_valid <= 1'b0;
            d_wen <= 1'b0;
            d_br_cond <= la32_pkg::BR_NONE;
            d_jirl <= 1'b0;
            d_link <= 1'b0;
            d_excp <= la32_pkg::ECODE_NONE;
        end
        else
        begin
            d_valid <= in_valid;
            d_wen <= wen;
            d_br_cond <= br_cond;
            d_jirl <= jirl;
            d_link <= link;
            d_excp <= excp;
        end
    end

    always_ff @(posedge clk)
    begin
        d_pc <= in_pc;
        d_rj <= rj;
        d_rk <= rk;
        d_rd <= rd;
        d_imm <= imm;
        d_use_imm <= use_imm;
        d_use_pc <= use_pc;
        d_alu_op <= alu_op;
    end

    a_excp_no_wen: assert property (@(posedge clk) disable iff (reset)
        d_excp != la32_pkg::ECODE_NONE |-> !d_wen)
        else $error("Faulting instruction left decode with a write enable");

endmodule

`default_nettype wire

/* verilog/la32_pkg.sv */
`default_nettype none

package la32_pkg;

    localparam int XLEN      = 32;
    localparam int NREGS     = 32;
    localparam int REG_IDX_W = 5;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        ALU_AND,
        ALU_OR,
        ALU_NOR,
        ALU_XOR,
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B // LU12I.W result
    } alu_op_t;

    // Compare branches map onto BR_EQ..BR_GEU by opcode offset
    typedef enum logic [2:0] {
        BR_NONE,
        BR_ALWAYS,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } br_cond_t;

    typedef enum logic [5:0] {
        ECODE_NONE = 6'h00,
        ECODE_ADEF = 6'h08,
        ECODE_SYS  = 6'h0B,
        ECODE_BRK  = 6'h0C,
        ECODE_INE  = 6'h0D
    } ecode_t;

    typedef enum logic [5:0] {
        OP_GRP0      = 6'b000000, // ALU reg-reg, immediates, SYSCALL, BREAK
        OP_LU12I     = 6'b000101,
        OP_PCADDU12I = 6'b000111,
        OP_JIRL      = 6'b010011,
        OP_B         = 6'b010100,
        OP_BL        = 6'b010101,
        OP_BEQ       = 6'b010110,
        OP_BNE       = 6'b010111,
        OP_BLT       = 6'b011000,
        OP_BGE       = 6'b011001,
        OP_BLTU      = 6'b011010,
        OP_BGEU      = 6'b011011
    } opcode_t;

endpackage

`default_nettype wire
